// File: verilog/x86_arch_pkg.sv
// x86 register file widths, read sizes and segment numbering
// import wherever a register or segment value is selected or sized
`default_nettype none

package x86_arch_pkg;

    localparam int gpr_width = 32;
    localparam int mmx_width = 64;
    localparam int seg_width = 16;
    localparam int reg_index_width = 3;

    // codes 0, 4, 6 and 7 read as zero
    typedef enum logic [2:0] {
        size_byte  = 3'd1,
        size_word  = 3'd2,
        size_dword = 3'd3,
        size_mmx   = 3'd5
    } reg_size_t;

    // codes 6 and 7 select no segment
    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs = 3'd1,
        seg_ss = 3'd2,
        seg_ds = 3'd3,
        seg_fs = 3'd4,
        seg_gs = 3'd5
    } seg_sel_t;

    // register numbers as encoded in the instruction
    localparam logic [reg_index_width-1:0] idx_eax = 3'd0;
    localparam logic [reg_index_width-1:0] idx_ecx = 3'd1;
    localparam logic [reg_index_width-1:0] idx_edx = 3'd2;
    localparam logic [reg_index_width-1:0] idx_ebx = 3'd3;
    localparam logic [reg_index_width-1:0] idx_esp = 3'd4;
    localparam logic [reg_index_width-1:0] idx_ebp = 3'd5;
    localparam logic [reg_index_width-1:0] idx_esi = 3'd6;
    localparam logic [reg_index_width-1:0] idx_edi = 3'd7;

    // segment register named by a seg_sel_t code, zero for the spare codes
    function automatic logic [seg_width-1:0] select_segment(
        input seg_sel_t sel,
        input logic [seg_width-1:0] es,
        input logic [seg_width-1:0] cs,
        input logic [seg_width-1:0] ss,
        input logic [seg_width-1:0] ds,
        input logic [seg_width-1:0] fs,
        input logic [seg_width-1:0] gs
    );
        case (sel)
            seg_es:  return es;
            seg_cs:  return cs;
            seg_ss:  return ss;
            seg_ds:  return ds;
            seg_fs:  return fs;
            seg_gs:  return gs;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/agen_pkg.sv
// operand kinds and widths of the address-generation stage
// import in every module that carries a stage operand
`default_nettype none

package agen_pkg;

    localparam int operand_width = 64;
    localparam int imm_width = 48;
    localparam int addr_width = 32;

    // source of one operand slot as decoded upstream
    typedef enum logic [2:0] {
        kind_none         = 3'd0,
        kind_register     = 3'd1,
        kind_segment      = 3'd2,
        kind_mmx_register = 3'd3,
        kind_mod_rm       = 3'd4,
        kind_immediate    = 3'd5,
        kind_memory       = 3'd6,
        kind_not_used     = 3'd7
    } operand_kind_t;

endpackage

`default_nettype wire

// File: verilog/gpr_size_selector.sv
// sized read of one general register or MMX register
// combinational, one instance per operand slot
`default_nettype none
`timescale 1ns/100ps

module gpr_size_selector
    import x86_arch_pkg::*;
    import agen_pkg::*;
(
    input  wire reg_size_t                     size,
    input  wire logic [reg_index_width-1:0]    index,
    input  wire logic [gpr_width-1:0]          gpr0, gpr1, gpr2, gpr3,
    input  wire logic [gpr_width-1:0]          gpr4, gpr5, gpr6, gpr7,
    input  wire logic [mmx_width-1:0]          mm0, mm1, mm2, mm3,
    input  wire logic [mmx_width-1:0]          mm4, mm5, mm6, mm7,
    output logic [operand_width-1:0]           value
);

    logic [gpr_width-1:0] gpr_sel;
    logic [gpr_width-1:0] byte_reg;
    logic [7:0][mmx_width-1:0] mm_regs;

    assign mm_regs = {mm7, mm6, mm5, mm4, mm3, mm2, mm1, mm0};

    always_comb begin
        case (index)
            idx_eax: gpr_sel = gpr0;
            idx_ecx: gpr_sel = gpr1;
            idx_edx: gpr_sel = gpr2;
            idx_ebx: gpr_sel = gpr3;
            idx_esp: gpr_sel = gpr4;
            idx_ebp: gpr_sel = gpr5;
            idx_esi: gpr_sel = gpr6;
            default: gpr_sel = gpr7;
        endcase
    end

    // byte numbers 4..7 are AH..BH, the high bytes of the first four
    always_comb begin
        case ({1'b0, index[1:0]})
            idx_eax: byte_reg = gpr0;
            idx_ecx: byte_reg = gpr1;
            idx_edx: byte_reg = gpr2;
            default: byte_reg = gpr3;
        endcase
    end

    always_comb begin
        case (size)
            size_byte:  value = operand_width'(index[2] ? byte_reg[15:8] : byte_reg[7:0]);
            size_word:  value = operand_width'(gpr_sel[15:0]);
            size_dword: value = operand_width'(gpr_sel);
            size_mmx:   value = operand_width'(mm_regs[index]);
            default:    value = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/string_address_gen.sv
// linear addresses of the string operands, ES:EDI and src:ESI
// source segment is DS unless a segment override is present
`default_nettype none
`timescale 1ns/100ps

module string_address_gen
    import x86_arch_pkg::*;
    import agen_pkg::*;
#(
    parameter int seg_shift = 4
) (
    input  wire logic [seg_width-1:0]  es, ds, cs, ss, fs, gs,
    input  wire seg_sel_t              seg_override,
    input  wire logic                  seg_override_valid,
    input  wire logic [gpr_width-1:0]  edi,
    input  wire logic [gpr_width-1:0]  esi,
    output logic [addr_width-1:0]      dest_addr,
    output logic [addr_width-1:0]      src_addr
);

    logic [seg_width-1:0] src_seg;
    logic [addr_width-1:0] dest_base;
    logic [addr_width-1:0] src_base;

    assign src_seg = seg_override_valid
        ? select_segment(seg_override, es, cs, ss, ds, fs, gs)
        : ds;

    // bits shifted past addr_width drop off, sums wrap mod 2^32
    assign dest_base = addr_width'(es) << seg_shift;
    assign src_base = addr_width'(src_seg) << seg_shift;

    assign dest_addr = dest_base + addr_width'(edi);
    assign src_addr = src_base + addr_width'(esi);

endmodule

`default_nettype wire

// File: verilog/operand_generator.sv
// picks one 64-bit operand by its kind, zero-extended
// also marks memory operands as addresses
`default_nettype none
`timescale 1ns/100ps

module operand_generator
    import x86_arch_pkg::*;
    import agen_pkg::*;
(
    input  wire operand_kind_t                 kind,
    input  wire logic [reg_index_width-1:0]    reg_index,
    input  wire reg_size_t                     size,
    input  wire logic [imm_width-1:0]          imm,
    input  wire logic [addr_width-1:0]         mem_addr,
    input  wire logic [gpr_width-1:0]          eax, ecx, edx, ebx,
    input  wire logic [gpr_width-1:0]          esp, ebp, esi, edi,
    input  wire logic [seg_width-1:0]          es, cs, ss, ds, fs, gs,
    input  wire logic [mmx_width-1:0]          mm0, mm1, mm2, mm3,
    input  wire logic [mmx_width-1:0]          mm4, mm5, mm6, mm7,
    output logic [operand_width-1:0]           operand,
    output logic                               is_address
);

    reg_size_t read_size;
    logic [operand_width-1:0] reg_value;
    logic [seg_width-1:0] seg_value;

    // mmx kind reads the full register whatever the operand size
    assign read_size = (kind == kind_mmx_register) ? size_mmx : size;

    gpr_size_selector sized_read_i (
        .size  (read_size),
        .index (reg_index),
        .gpr0  (eax), .gpr1 (ecx), .gpr2 (edx), .gpr3 (ebx),
        .gpr4  (esp), .gpr5 (ebp), .gpr6 (esi), .gpr7 (edi),
        .mm0   (mm0), .mm1 (mm1), .mm2 (mm2), .mm3 (mm3),
        .mm4   (mm4), .mm5 (mm5), .mm6 (mm6), .mm7 (mm7),
        .value (reg_value)
    );

    assign seg_value = select_segment(seg_sel_t'(reg_index), es, cs, ss, ds, fs, gs);

    // none, mod r/m and not-used all give zero
    always_comb begin
        case (kind)
            kind_register:     operand = reg_value;
            kind_mmx_register: operand = reg_value;
            kind_segment:      operand = operand_width'(seg_value);
            kind_immediate:    operand = operand_width'(imm);
            kind_memory:       operand = operand_width'(mem_addr);
            default:           operand = '0;
        endcase
    end

    assign is_address = (kind == kind_memory);

endmodule

`default_nettype wire

// File: verilog/agen_stage_reg.sv
// one-entry output register of the stage with valid/ready
// holds its item under back-pressure, flush drops it
`default_nettype none
`timescale 1ns/100ps

module agen_stage_reg
    import agen_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      flush,
    input  wire logic                      in_valid,
    output logic                           in_ready,
    input  wire logic [operand_width-1:0]  op0_in,
    input  wire logic [operand_width-1:0]  op1_in,
    input  wire logic                      op0_is_address_in,
    input  wire logic                      op1_is_address_in,
    output logic                           out_valid,
    input  wire logic                      out_ready,
    output logic [operand_width-1:0]       op0,
    output logic [operand_width-1:0]       op1,
    output logic                           op0_is_address,
    output logic                           op1_is_address
);

    logic capture;

    // free when empty or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign capture = in_valid && in_ready && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            op0 <= op0_in;
            op1 <= op1_in;
            op0_is_address <= op0_is_address_in;
            op1_is_address <= op1_is_address_in;
        end
    end

endmodule

`default_nettype wire

// File: verilog/address_generation_top.sv
// address-generation stage, two operand slots into one output register
// r_ side comes from register read, a_ side goes to memory access
`default_nettype none
`timescale 1ns/100ps

module address_generation_top
    import x86_arch_pkg::*;
    import agen_pkg::*;
#(
    parameter int seg_shift = 4
) (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          flush,
    input  wire logic                          r_valid,
    output logic                               r_ready,
    input  wire reg_size_t                     r_size,
    input  wire operand_kind_t                 r_op0_kind,
    input  wire operand_kind_t                 r_op1_kind,
    input  wire logic [reg_index_width-1:0]    r_op0_reg,
    input  wire logic [reg_index_width-1:0]    r_op1_reg,
    input  wire logic [imm_width-1:0]          r_imm,
    input  wire seg_sel_t                      r_seg_override,
    input  wire logic                          r_seg_override_valid,
    input  wire logic [gpr_width-1:0]          r_eax, r_ecx, r_edx, r_ebx,
    input  wire logic [gpr_width-1:0]          r_esp, r_ebp, r_esi, r_edi,
    input  wire logic [seg_width-1:0]          r_cs, r_ds, r_es, r_fs, r_gs, r_ss,
    input  wire logic [mmx_width-1:0]          r_mm0, r_mm1, r_mm2, r_mm3,
    input  wire logic [mmx_width-1:0]          r_mm4, r_mm5, r_mm6, r_mm7,
    output logic                               a_valid,
    input  wire logic                          a_ready,
    output logic [operand_width-1:0]           a_op0,
    output logic [operand_width-1:0]           a_op1,
    output logic                               a_op0_is_address,
    output logic                               a_op1_is_address
);

    logic [addr_width-1:0] dest_addr;
    logic [addr_width-1:0] src_addr;
    logic [operand_width-1:0] op0_value;
    logic [operand_width-1:0] op1_value;
    logic op0_is_address;
    logic op1_is_address;

    string_address_gen #(
        .seg_shift (seg_shift)
    ) string_addr_i (
        .es (r_es), .ds (r_ds), .cs (r_cs), .ss (r_ss), .fs (r_fs), .gs (r_gs),
        .seg_override       (r_seg_override),
        .seg_override_valid (r_seg_override_valid),
        .edi                (r_edi),
        .esi                (r_esi),
        .dest_addr          (dest_addr),
        .src_addr           (src_addr)
    );

    // operand 0 takes ES:EDI as its memory operand
    operand_generator op0_gen_i (
        .kind (r_op0_kind), .reg_index (r_op0_reg), .size (r_size),
        .imm (r_imm), .mem_addr (dest_addr),
        .eax (r_eax), .ecx (r_ecx), .edx (r_edx), .ebx (r_ebx),
        .esp (r_esp), .ebp (r_ebp), .esi (r_esi), .edi (r_edi),
        .es (r_es), .cs (r_cs), .ss (r_ss), .ds (r_ds), .fs (r_fs), .gs (r_gs),
        .mm0 (r_mm0), .mm1 (r_mm1), .mm2 (r_mm2), .mm3 (r_mm3),
        .mm4 (r_mm4), .mm5 (r_mm5), .mm6 (r_mm6), .mm7 (r_mm7),
        .operand (op0_value), .is_address (op0_is_address)
    );

    // operand 1 takes the source string address
    operand_generator op1_gen_i (
        .kind (r_op1_kind), .reg_index (r_op1_reg), .size (r_size),
        .imm (r_imm), .mem_addr (src_addr),
        .eax (r_eax), .ecx (r_ecx), .edx (r_edx), .ebx (r_ebx),
        .esp (r_esp), .ebp (r_ebp), .esi (r_esi), .edi (r_edi),
        .es (r_es), .cs (r_cs), .ss (r_ss), .ds (r_ds), .fs (r_fs), .gs (r_gs),
        .mm0 (r_mm0), .mm1 (r_mm1), .mm2 (r_mm2), .mm3 (r_mm3),
        .mm4 (r_mm4), .mm5 (r_mm5), .mm6 (r_mm6), .mm7 (r_mm7),
        .operand (op1_value), .is_address (op1_is_address)
    );

    agen_stage_reg stage_reg_i (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .in_valid          (r_valid),
        .in_ready          (r_ready),
        .op0_in            (op0_value),
        .op1_in            (op1_value),
        .op0_is_address_in (op0_is_address),
        .op1_is_address_in (op1_is_address),
        .out_valid         (a_valid),
        .out_ready         (a_ready),
        .op0               (a_op0),
        .op1               (a_op1),
        .op0_is_address    (a_op0_is_address),
        .op1_is_address    (a_op1_is_address)
    );

endmodule

`default_nettype wire

// File: tests/agen_clock_gen.sv
// clock and synchronous reset for the address-generation testbench
// 20 ns period, reset held high for the first reset_cycles rising edges
`default_nettype none
`timescale 1ns/100ps

module agen_clock_gen #(
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release shortly after an edge, like every other testbench input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/agen_checker.sv
// handshake assertions for the stage output register
// bound into every agen_stage_reg instance
`default_nettype none
`timescale 1ns/100ps

module agen_checker
    import agen_pkg::*;
(
    input wire logic                      clk,
    input wire logic                      reset,
    input wire logic                      flush,
    input wire logic                      out_valid,
    input wire logic                      out_ready,
    input wire logic [operand_width-1:0]  op0,
    input wire logic [operand_width-1:0]  op1,
    input wire logic                      op0_is_address,
    input wire logic                      op1_is_address
);

    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // a stalled item keeps every field until it is accepted
    stall_holds_outputs: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(op0) && $stable(op1)
            && $stable(op0_is_address) && $stable(op1_is_address))
        else $error("held item changed or vanished under back-pressure");

    flush_clears_valid: assert property (@(posedge clk) flush |=> !out_valid)
        else $error("out_valid high in the cycle after a flush");

endmodule

bind agen_stage_reg agen_checker handshake_checker_i (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .op0            (op0),
    .op1            (op1),
    .op0_is_address (op0_is_address),
    .op1_is_address (op1_is_address)
);

`default_nettype wire

// File: tests/agen_tb.sv
// testbench for the address-generation stage
// reads vectors from tests/agen_input.txt, stalls a_ready at random, checks order
`default_nettype none
`timescale 1ns/100ps

module agen_tb
    import x86_arch_pkg::*;
    import agen_pkg::*;
();

    localparam int max_cycles = 2000;

    logic clk, reset, flush;
    logic r_valid, r_ready, a_valid, a_ready;
    reg_size_t r_size;
    operand_kind_t r_op0_kind, r_op1_kind;
    logic [reg_index_width-1:0] r_op0_reg, r_op1_reg;
    logic [imm_width-1:0] r_imm;
    seg_sel_t r_seg_override;
    logic r_seg_override_valid;
    logic [operand_width-1:0] a_op0, a_op1;
    logic a_op0_is_address, a_op1_is_address;

    // vectors in file order
    string names[$];
    logic [2:0] v_size[$], v_k0[$], v_r0[$], v_k1[$], v_r1[$], v_ovr[$];
    logic [imm_width-1:0] v_imm[$];
    logic v_ovr_valid[$], v_flush[$], v_a0[$], v_a1[$];
    logic [operand_width-1:0] v_op0[$], v_op1[$];
    int expected[$];
    int failures = 0;
    int tests_done = 0;
    int flushed_count = 0;

    agen_clock_gen #(.reset_cycles (8)) clock_gen_i (.clk (clk), .reset (reset));

    address_generation_top #(
        .seg_shift (4)
    ) dut_i (
        .clk (clk), .reset (reset), .flush (flush),
        .r_valid (r_valid), .r_ready (r_ready), .r_size (r_size),
        .r_op0_kind (r_op0_kind), .r_op1_kind (r_op1_kind),
        .r_op0_reg (r_op0_reg), .r_op1_reg (r_op1_reg), .r_imm (r_imm),
        .r_seg_override (r_seg_override), .r_seg_override_valid (r_seg_override_valid),
        // fixed register file contents behind the expected values in the vector file
        .r_eax (32'h11223344), .r_ecx (32'h55667788), .r_edx (32'h99aabbcc),
        .r_ebx (32'hddeeff01), .r_esp (32'h0badf00d), .r_ebp (32'hcafebabe),
        .r_esi (32'hfff01234), .r_edi (32'h00005678),
        .r_cs (16'h0008), .r_ss (16'h0010), .r_ds (16'h0018), .r_es (16'h0020),
        .r_fs (16'h0abc), .r_gs (16'hff00),
        .r_mm0 (64'h8000000000000000), .r_mm1 (64'h8111111111111111),
        .r_mm2 (64'h8222222222222222), .r_mm3 (64'h8333333333333333),
        .r_mm4 (64'h8444444444444444), .r_mm5 (64'h8555555555555555),
        .r_mm6 (64'h8666666666666666), .r_mm7 (64'h8777777777777777),
        .a_valid (a_valid), .a_ready (a_ready), .a_op0 (a_op0), .a_op1 (a_op1),
        .a_op0_is_address (a_op0_is_address), .a_op1_is_address (a_op1_is_address)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic read_vectors();
        int fd;
        int pos;
        int count;
        string line;
        logic [2:0] size, k0, r0, k1, r1, ovr;
        logic [imm_width-1:0] imm;
        logic ovr_valid, fl, a0, a1;
        logic [operand_width-1:0] op0, op1;
        fd = $fopen("tests/agen_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/agen_input.txt");
            failures++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;
            end
            pos = 0;
            while (pos < line.len() && line.getc(pos) != " ") begin
                pos++;
            end
            count = $sscanf(line.substr(pos, line.len() - 1),
                "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                size, k0, r0, k1, r1, imm, ovr, ovr_valid, fl, op0, a0, op1, a1);
            if (count != 13) begin
                $display("malformed vector line: %s", line);
                failures++;
                continue;
            end
            names.push_back(line.substr(0, pos - 1));
            v_size.push_back(size);
            v_k0.push_back(k0);
            v_r0.push_back(r0);
            v_k1.push_back(k1);
            v_r1.push_back(r1);
            v_imm.push_back(imm);
            v_ovr.push_back(ovr);
            v_ovr_valid.push_back(ovr_valid);
            v_flush.push_back(fl);
            v_op0.push_back(op0);
            v_a0.push_back(a0);
            v_op1.push_back(op1);
            v_a1.push_back(a1);
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int idx);
        r_valid = 1'b1;
        r_size = reg_size_t'(v_size[idx]);
        r_op0_kind = operand_kind_t'(v_k0[idx]);
        r_op0_reg = v_r0[idx];
        r_op1_kind = operand_kind_t'(v_k1[idx]);
        r_op1_reg = v_r1[idx];
        r_imm = v_imm[idx];
        r_seg_override = seg_sel_t'(v_ovr[idx]);
        r_seg_override_valid = v_ovr_valid[idx];
    endtask

    task automatic check_output(input int idx);
        logic ok;
        ok = 1'b1;
        if (a_op0 !== v_op0[idx]) begin
            $display("MISMATCH %s a_op0 expected %h actual %h", names[idx], v_op0[idx], a_op0);
            ok = 1'b0;
        end
        if (a_op0_is_address !== v_a0[idx]) begin
            $display("MISMATCH %s a_op0_is_address expected %b actual %b",
                names[idx], v_a0[idx], a_op0_is_address);
            ok = 1'b0;
        end
        if (a_op1 !== v_op1[idx]) begin
            $display("MISMATCH %s a_op1 expected %h actual %h", names[idx], v_op1[idx], a_op1);
            ok = 1'b0;
        end
        if (a_op1_is_address !== v_a1[idx]) begin
            $display("MISMATCH %s a_op1_is_address expected %b actual %b",
                names[idx], v_a1[idx], a_op1_is_address);
            ok = 1'b0;
        end
        if (ok) begin
            $display("test %s: ok", names[idx]);
        end else begin
            $display("test %s: failed", names[idx]);
            failures++;
        end
        tests_done++;
    endtask

    initial begin
        logic [31:0] lfsr;
        int cycles;
        int next_vec;
        int victim;
        logic holding;
        logic check_flushed;
        logic ready_exp;
        flush = 1'b0;
        r_valid = 1'b0;
        a_ready = 1'b0;
        r_size = size_byte;
        r_op0_kind = kind_none;
        r_op1_kind = kind_none;
        r_op0_reg = '0;
        r_op1_reg = '0;
        r_imm = '0;
        r_seg_override = seg_es;
        r_seg_override_valid = 1'b0;
        lfsr = 32'hedab8e5c;
        next_vec = 0;
        victim = -1;
        holding = 1'b0;
        check_flushed = 1'b0;
        read_vectors();
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (reset !== 1'b0 && cycles < 50);
        if (reset !== 1'b0) begin
            $display("timeout: reset never released");
            failures++;
        end else begin
            cycles = 0;
            while ((next_vec < names.size() || expected.size() > 0 || holding)
                   && cycles < max_cycles) begin
                @(posedge clk);
                #1;
                cycles++;
                flush = 1'b0;
                if (holding) begin
                    // drop the held earlier item before the marked vector
                    if (!a_valid) begin
                        $display("item %s was not held for the flush", names[victim]);
                        failures++;
                    end
                    flush = 1'b1;
                    a_ready = 1'b0;
                    r_valid = 1'b0;
                    holding = 1'b0;
                    check_flushed = 1'b1;
                    flushed_count++;
                    $display("test %s: held and flushed", names[victim]);
                end else begin
                    lfsr = lfsr_step(lfsr);
                    a_ready = lfsr[0];
                    if (next_vec < names.size()) begin
                        drive_vector(next_vec);
                    end else begin
                        r_valid = 1'b0;
                    end
                end
                #1;
                if (next_vec == 0 && a_valid !== 1'b0) begin
                    $display("a_valid high before any input was accepted");
                    failures++;
                end
                // stage takes a new item when empty or when the held one leaves
                ready_exp = !a_valid || a_ready;
                if (r_ready !== ready_exp) begin
                    $display("MISMATCH ready_rule r_ready expected %b actual %b",
                        ready_exp, r_ready);
                    failures++;
                end
                if (check_flushed && !flush) begin
                    if (a_valid) begin
                        $display("a_valid still high after a flush");
                        failures++;
                    end
                    check_flushed = 1'b0;
                end
                if (a_valid && a_ready) begin
                    if (expected.size() == 0) begin
                        $display("a_valid with no item in flight");
                        failures++;
                    end else begin
                        check_output(expected.pop_front());
                    end
                end
                if (r_valid && r_ready && !flush) begin
                    if (next_vec + 1 < names.size() && v_flush[next_vec + 1]) begin
                        holding = 1'b1;
                        victim = next_vec;
                    end else begin
                        expected.push_back(next_vec);
                    end
                    next_vec++;
                end
            end
            if (next_vec < names.size() || expected.size() > 0 || holding) begin
                $display("timeout: %0d of %0d vectors accepted, %0d outputs missing",
                    next_vec, names.size(), expected.size());
                failures++;
            end
        end
        $display("%0d checked, %0d flushed, %0d failures", tests_done, flushed_count, failures);
        if (failures == 0 && tests_done > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/agen_input.txt
// name size op0_kind op0_reg op1_kind op1_reg imm seg_ovr seg_ovr_valid flush_before
//   exp_op0 exp_op0_is_addr exp_op1 exp_op1_is_addr, every field after the name in hex
byte_al_ah      1 1 0 1 4 0 0 0 0 44 0 33 0
byte_cl_ch      1 1 1 1 5 0 0 0 0 88 0 77 0
byte_bl_dh      1 1 3 1 6 0 0 0 0 01 0 bb 0
byte_dl_bh      1 1 2 1 7 0 0 0 0 cc 0 ff 0
word_sp_bp      2 1 4 1 5 0 0 0 0 f00d 0 babe 0
dword_si_di     3 1 6 1 7 0 0 0 0 fff01234 0 5678 0
mmx_size_mm2    5 1 2 1 7 0 0 0 0 8222222222222222 0 8777777777777777 0
mmx_kind_mm0    3 3 0 3 5 0 0 0 0 8000000000000000 0 8555555555555555 0
seg_es_cs       3 2 0 2 1 0 0 0 0 20 0 8 0
seg_ss_ds       3 2 2 2 3 0 0 0 0 10 0 18 0
seg_fs_gs       3 2 4 2 5 0 0 0 0 abc 0 ff00 0
seg_spare       3 2 6 2 7 0 0 0 0 0 0 0 0
immediate       3 5 0 5 0 87654321abcd 0 0 0 87654321abcd 0 87654321abcd 0
string_ds       3 6 0 6 0 0 0 0 0 5878 1 fff013b4 1
string_cs       3 6 0 6 0 0 1 1 0 5878 1 fff012b4 1
flush_victim    3 1 0 5 0 123456 0 0 0 11223344 0 123456 0
string_gs_wrap  3 6 0 6 0 0 5 1 1 5878 1 234 1
string_fs       3 6 0 6 0 0 4 1 0 5878 1 fff0bdf4 1
string_spare    3 6 0 6 0 0 6 1 0 5878 1 fff01234 1
string_no_ovr   3 6 0 6 0 0 5 0 0 5878 1 fff013b4 1
kind_none_modrm 3 0 3 4 1 0 0 0 0 0 0 0 0
kind_not_used   0 7 0 1 1 0 0 0 0 0 0 0 0
size_code4      4 1 0 5 0 abcdef 0 0 0 0 0 abcdef 0
mixed_addr_reg  3 6 0 1 0 0 0 0 0 5878 1 11223344 0

// File: sources.f
verilog/x86_arch_pkg.sv
verilog/agen_pkg.sv
verilog/gpr_size_selector.sv
verilog/string_address_gen.sv
verilog/operand_generator.sv
verilog/agen_stage_reg.sv
verilog/address_generation_top.sv
tests/agen_clock_gen.sv
tests/agen_checker.sv
tests/agen_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the address-generation testbench with Verilator, runs it and judges the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module agen_tb \
    -f sources.f --Mdir "$build_dir" -o agen_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/agen_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q 'Test failures found' "$log_file"; then
    exit 1
fi
if ! grep -q 'All tests passed!' "$log_file"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
